// File: filelist.f
source/ex_ft_pkg.sv
source/alu_lane.sv
source/lane_voter.sv
source/fault_monitor.sv
source/fault_csr.sv
source/ex_writeback.sv
source/ex_stage_ft.sv
test/tb_ex_stage_ft.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench and the execute stage with Verilator, then run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f filelist.f \
  --top-module tb_ex_stage_ft \
  -o sim_tb

./obj_dir/sim_tb

// File: source/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module alu_lane (
  input  ex_ft_pkg::alu_op_e               op_i,
  input  logic [ex_ft_pkg::data_width-1:0] a_i,
  input  logic [ex_ft_pkg::data_width-1:0] b_i,
  // Fault injection for this lane
  input  logic                             inj_en_i,
  input  logic [ex_ft_pkg::data_width-1:0] inj_pat_i,
  output logic [ex_ft_pkg::data_width-1:0] result_o
);

  import ex_ft_pkg::*;

  logic [4:0]            shamt;
  logic [data_width-1:0] raw_result;
  logic [data_width-1:0] fault_xor;

  // Shift amount from the low bits of b
  assign shamt = b_i[4:0];

  ////////////////////
  // Operation
  ////////////////////

  always_comb begin
    raw_result = '0;
    case (op_i)
      op_add: raw_result = a_i + b_i;
      op_sub: raw_result = a_i - b_i;
      op_and: raw_result = a_i & b_i;
      op_or:  raw_result = a_i | b_i;
      op_xor: raw_result = a_i ^ b_i;
      op_sll: raw_result = a_i << shamt;
      op_srl: raw_result = a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      op_sra: raw_result = $signed(a_i) >>> shamt;
      // Compares only drive bit 0
      op_slt: raw_result[0] = $signed(a_i) < $signed(b_i);
      op_sltu: raw_result[0] = a_i < b_i;
      op_eq: raw_result[0] = a_i == b_i;
      default: raw_result = '0;
    endcase
  end

  ////////////////////
  // Fault injection
  ////////////////////

  // Enabled lane flips the pattern bits, models a faulty lane
  assign fault_xor = inj_en_i ? inj_pat_i : '0;
  assign result_o  = raw_result ^ fault_xor;

endmodule

`default_nettype wire

// File: source/ex_ft_pkg.sv
`default_nettype none

package ex_ft_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Datapath word
  localparam int unsigned data_width     = 32;
  // Register block address
  localparam int unsigned reg_addr_width = 4;
  // Register file write address
  localparam int unsigned waddr_width    = 6;
  // Redundant ALU lanes and their index
  localparam int unsigned num_lanes      = 4;
  localparam int unsigned lane_idx_width = 2;
  // Mismatch counters and threshold, default for the top level
  localparam int unsigned cnt_width      = 8;

  ////////////////////
  // Opcodes and modes
  ////////////////////

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    // Shifts use the low 5 bits of b
    op_sll  = 4'd5,
    op_srl  = 4'd6,
    op_sra  = 4'd7,
    // Compares give 1 or 0
    op_slt  = 4'd8,
    op_sltu = 4'd9,
    op_eq   = 4'd10
  } alu_op_e;

  // Majority vote over three lanes, or one named lane
  typedef enum logic {
    vote_tmr    = 1'b0,
    vote_bypass = 1'b1
  } vote_mode_e;

  ////////////////////
  // Register block map
  ////////////////////

  // Bits 1:0 lane index, bit 2 mode
  localparam logic [reg_addr_width-1:0] addr_ctrl     = 4'd0;
  localparam logic [reg_addr_width-1:0] addr_thresh   = 4'd1;
  // Bits 3:0 select the lanes to corrupt
  localparam logic [reg_addr_width-1:0] addr_inj_mask = 4'd2;
  localparam logic [reg_addr_width-1:0] addr_inj_pat  = 4'd3;
  // Read only, permanent fault flags
  localparam logic [reg_addr_width-1:0] addr_perm     = 4'd4;
  // Lane counters at 8 to 11, a write clears the counter
  localparam logic [reg_addr_width-1:0] addr_cnt_base = 4'd8;

endpackage

`default_nettype wire

// File: source/ex_stage_ft.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_ft #(
  parameter int unsigned cnt_width = ex_ft_pkg::cnt_width
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // ALU operation
  input  logic                                 alu_en_i,
  input  ex_ft_pkg::alu_op_e                   alu_operator_i,
  input  logic [ex_ft_pkg::data_width-1:0]     alu_operand_a_i,
  input  logic [ex_ft_pkg::data_width-1:0]     alu_operand_b_i,
  input  logic [ex_ft_pkg::waddr_width-1:0]    regfile_alu_waddr_i,
  input  logic                                 regfile_alu_we_i,
  // CSR access
  input  logic                                 csr_access_i,
  input  logic [ex_ft_pkg::data_width-1:0]     csr_rdata_i,
  // Load
  input  logic                                 lsu_en_i,
  input  logic                                 lsu_err_i,
  input  logic [ex_ft_pkg::waddr_width-1:0]    lsu_waddr_i,
  input  logic [ex_ft_pkg::data_width-1:0]     lsu_rdata_i,
  // Register block port
  input  logic [ex_ft_pkg::reg_addr_width-1:0] mhpm_addr_i,
  input  logic                                 mhpm_we_i,
  input  logic                                 mhpm_re_i,
  input  logic [ex_ft_pkg::data_width-1:0]     mhpm_wdata_i,
  output logic [ex_ft_pkg::data_width-1:0]     mhpm_rdata_o,
  // Forwarding and load write ports
  output logic                                 regfile_alu_we_fw_o,
  output logic [ex_ft_pkg::waddr_width-1:0]    regfile_alu_waddr_fw_o,
  output logic [ex_ft_pkg::data_width-1:0]     regfile_alu_wdata_fw_o,
  output logic                                 regfile_we_wb_o,
  output logic [ex_ft_pkg::waddr_width-1:0]    regfile_waddr_wb_o,
  output logic [ex_ft_pkg::data_width-1:0]     regfile_wdata_wb_o,
  // Fault status
  output logic                                 err_detected_o,
  output logic                                 err_corrected_o,
  output logic [ex_ft_pkg::num_lanes-1:0]      permanent_faulty_o,
  output logic                                 ex_valid_o
);

  import ex_ft_pkg::*;

  logic [data_width-1:0]     lane_res [num_lanes];
  logic [num_lanes-1:0]      inj_mask;
  logic [data_width-1:0]     inj_pat;
  logic [lane_idx_width-1:0] lane_sel;
  vote_mode_e                mode;
  logic [cnt_width-1:0]      thresh;
  logic [num_lanes-1:0]      clr;
  logic [cnt_width-1:0]      cnt0;
  logic [cnt_width-1:0]      cnt1;
  logic [cnt_width-1:0]      cnt2;
  logic [cnt_width-1:0]      cnt3;
  logic [num_lanes-1:0]      perm;
  logic [data_width-1:0]     voted_result;
  logic                      vote_det;
  logic                      vote_cor;
  logic [num_lanes-1:0]      mismatch;

  ////////////////////
  // ALU lanes
  ////////////////////

  // Same operation into every lane, each with its own injection bit
  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    alu_lane i_alu_lane (
      .op_i      ( alu_operator_i  ),
      .a_i       ( alu_operand_a_i ),
      .b_i       ( alu_operand_b_i ),
      .inj_en_i  ( inj_mask[i]     ),
      .inj_pat_i ( inj_pat         ),
      .result_o  ( lane_res[i]     )
    );
  end

  lane_voter i_lane_voter (
    .lane0_i         ( lane_res[0]  ),
    .lane1_i         ( lane_res[1]  ),
    .lane2_i         ( lane_res[2]  ),
    .lane3_i         ( lane_res[3]  ),
    .lane_sel_i      ( lane_sel     ),
    .mode_i          ( mode         ),
    .result_o        ( voted_result ),
    .err_detected_o  ( vote_det     ),
    .err_corrected_o ( vote_cor     ),
    .mismatch_o      ( mismatch     )
  );

  // Flags only mean something for an ALU op
  assign err_detected_o  = alu_en_i && vote_det;
  assign err_corrected_o = alu_en_i && vote_cor;

  ////////////////////
  // Fault bookkeeping
  ////////////////////

  fault_monitor #(
    .cnt_width ( cnt_width )
  ) i_fault_monitor (
    .clk        ( clk      ),
    .rst_n      ( rst_n    ),
    .valid_i    ( alu_en_i ),
    .mismatch_i ( mismatch ),
    .thresh_i   ( thresh   ),
    .clr_i      ( clr      ),
    .cnt0_o     ( cnt0     ),
    .cnt1_o     ( cnt1     ),
    .cnt2_o     ( cnt2     ),
    .cnt3_o     ( cnt3     ),
    .perm_o     ( perm     )
  );

  fault_csr #(
    .cnt_width ( cnt_width )
  ) i_fault_csr (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .mhpm_addr_i  ( mhpm_addr_i  ),
    .mhpm_we_i    ( mhpm_we_i    ),
    .mhpm_re_i    ( mhpm_re_i    ),
    .mhpm_wdata_i ( mhpm_wdata_i ),
    .mhpm_rdata_o ( mhpm_rdata_o ),
    .lane_sel_o   ( lane_sel     ),
    .mode_o       ( mode         ),
    .thresh_o     ( thresh       ),
    .inj_mask_o   ( inj_mask     ),
    .inj_pat_o    ( inj_pat      ),
    .clr_o        ( clr          ),
    .cnt0_i       ( cnt0         ),
    .cnt1_i       ( cnt1         ),
    .cnt2_i       ( cnt2         ),
    .cnt3_i       ( cnt3         ),
    .perm_i       ( perm         )
  );

  assign permanent_faulty_o = perm;

  ////////////////////
  // Write-back
  ////////////////////

  ex_writeback i_ex_writeback (
    .clk                    ( clk                    ),
    .rst_n                  ( rst_n                  ),
    .alu_en_i               ( alu_en_i               ),
    .csr_access_i           ( csr_access_i           ),
    .alu_result_i           ( voted_result           ),
    .csr_rdata_i            ( csr_rdata_i            ),
    .alu_waddr_i            ( regfile_alu_waddr_i    ),
    .alu_we_i               ( regfile_alu_we_i       ),
    .lsu_en_i               ( lsu_en_i               ),
    .lsu_err_i              ( lsu_err_i              ),
    .lsu_waddr_i            ( lsu_waddr_i            ),
    .lsu_rdata_i            ( lsu_rdata_i            ),
    .regfile_alu_we_fw_o    ( regfile_alu_we_fw_o    ),
    .regfile_alu_waddr_fw_o ( regfile_alu_waddr_fw_o ),
    .regfile_alu_wdata_fw_o ( regfile_alu_wdata_fw_o ),
    .regfile_we_wb_o        ( regfile_we_wb_o        ),
    .regfile_waddr_wb_o     ( regfile_waddr_wb_o     ),
    .regfile_wdata_wb_o     ( regfile_wdata_wb_o     )
  );

  // No back-pressure, any strobe is a valid EX cycle
  assign ex_valid_o = alu_en_i || csr_access_i || lsu_en_i;

endmodule

`default_nettype wire

// File: source/ex_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module ex_writeback (
  input  logic                              clk,
  input  logic                              rst_n,
  // ALU and CSR results
  input  logic                              alu_en_i,
  input  logic                              csr_access_i,
  input  logic [ex_ft_pkg::data_width-1:0]  alu_result_i,
  input  logic [ex_ft_pkg::data_width-1:0]  csr_rdata_i,
  input  logic [ex_ft_pkg::waddr_width-1:0] alu_waddr_i,
  input  logic                              alu_we_i,
  // Load side
  input  logic                              lsu_en_i,
  input  logic                              lsu_err_i,
  input  logic [ex_ft_pkg::waddr_width-1:0] lsu_waddr_i,
  input  logic [ex_ft_pkg::data_width-1:0]  lsu_rdata_i,
  // Forwarding port to ID
  output logic                              regfile_alu_we_fw_o,
  output logic [ex_ft_pkg::waddr_width-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_ft_pkg::data_width-1:0]  regfile_alu_wdata_fw_o,
  // Load write port
  output logic                              regfile_we_wb_o,
  output logic [ex_ft_pkg::waddr_width-1:0] regfile_waddr_wb_o,
  output logic [ex_ft_pkg::data_width-1:0]  regfile_wdata_wb_o
);

  import ex_ft_pkg::*;

  logic                   lsu_we_q;
  logic [waddr_width-1:0] lsu_waddr_q;

  ////////////////////
  // ALU write port
  ////////////////////

  // Write only while an ALU or CSR op is in EX
  assign regfile_alu_we_fw_o    = alu_we_i && (alu_en_i || csr_access_i);
  assign regfile_alu_waddr_fw_o = alu_waddr_i;
  assign regfile_alu_wdata_fw_o = csr_access_i ? csr_rdata_i : alu_result_i;

  ////////////////////
  // EX/WB register
  ////////////////////

  // Faulted load never writes, idle cycles flush the enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else begin
      lsu_we_q <= lsu_en_i && !lsu_err_i;
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_en_i) begin
      lsu_waddr_q <= lsu_waddr_i;
    end
  end

  // Load data arrives in the WB cycle
  assign regfile_we_wb_o    = lsu_we_q;
  assign regfile_waddr_wb_o = lsu_waddr_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

`default_nettype wire

// File: source/fault_csr.sv
`timescale 1ns/1ps
`default_nettype none

module fault_csr #(
  parameter int unsigned cnt_width = ex_ft_pkg::cnt_width
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Counter-style access port
  input  logic [ex_ft_pkg::reg_addr_width-1:0] mhpm_addr_i,
  input  logic                                 mhpm_we_i,
  input  logic                                 mhpm_re_i,
  input  logic [ex_ft_pkg::data_width-1:0]     mhpm_wdata_i,
  output logic [ex_ft_pkg::data_width-1:0]     mhpm_rdata_o,
  // Configuration out
  output logic [ex_ft_pkg::lane_idx_width-1:0] lane_sel_o,
  output ex_ft_pkg::vote_mode_e                mode_o,
  output logic [cnt_width-1:0]                 thresh_o,
  output logic [ex_ft_pkg::num_lanes-1:0]      inj_mask_o,
  output logic [ex_ft_pkg::data_width-1:0]     inj_pat_o,
  output logic [ex_ft_pkg::num_lanes-1:0]      clr_o,
  // Monitor state in
  input  logic [cnt_width-1:0]                 cnt0_i,
  input  logic [cnt_width-1:0]                 cnt1_i,
  input  logic [cnt_width-1:0]                 cnt2_i,
  input  logic [cnt_width-1:0]                 cnt3_i,
  input  logic [ex_ft_pkg::num_lanes-1:0]      perm_i
);

  import ex_ft_pkg::*;

  logic [lane_idx_width-1:0] lane_sel_q;
  vote_mode_e                mode_q;
  logic [cnt_width-1:0]      thresh_q;
  logic [num_lanes-1:0]      inj_mask_q;
  logic [data_width-1:0]     inj_pat_q;
  logic [data_width-1:0]     rdata_d;
  logic [data_width-1:0]     rdata_q;
  logic [cnt_width-1:0]      cnts [num_lanes];
  logic [lane_idx_width-1:0] cnt_idx;
  logic                      cnt_hit;

  assign cnts[0] = cnt0_i;
  assign cnts[1] = cnt1_i;
  assign cnts[2] = cnt2_i;
  assign cnts[3] = cnt3_i;

  // Low bits pick the lane in the counter window
  assign cnt_idx = mhpm_addr_i[lane_idx_width-1:0];
  assign cnt_hit = mhpm_addr_i[reg_addr_width-1:lane_idx_width] ==
                   addr_cnt_base[reg_addr_width-1:lane_idx_width];

  ////////////////////
  // Writes
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Vote over lanes 0..2 with the threshold out of reach
      lane_sel_q <= '1;
      mode_q     <= vote_tmr;
      thresh_q   <= '1;
      inj_mask_q <= '0;
    end else if (mhpm_we_i) begin
      case (mhpm_addr_i)
        addr_ctrl: begin
          lane_sel_q <= mhpm_wdata_i[lane_idx_width-1:0];
          mode_q     <= vote_mode_e'(mhpm_wdata_i[lane_idx_width]);
        end
        addr_thresh:   thresh_q   <= mhpm_wdata_i[cnt_width-1:0];
        addr_inj_mask: inj_mask_q <= mhpm_wdata_i[num_lanes-1:0];
        default: ;
      endcase
    end
  end

  // Injection XOR pattern
  always_ff @(posedge clk) begin
    if (mhpm_we_i && (mhpm_addr_i == addr_inj_pat)) begin
      inj_pat_q <= mhpm_wdata_i;
    end
  end

  // Counter write turns into a one-cycle clear
  always_comb begin
    clr_o = '0;
    if (mhpm_we_i && cnt_hit) begin
      clr_o[cnt_idx] = 1'b1;
    end
  end

  ////////////////////
  // Reads
  ////////////////////

  always_comb begin
    rdata_d = '0;
    case (mhpm_addr_i)
      addr_ctrl: begin
        rdata_d[lane_idx_width-1:0] = lane_sel_q;
        rdata_d[lane_idx_width]     = mode_q;
      end
      addr_thresh:   rdata_d[cnt_width-1:0] = thresh_q;
      addr_inj_mask: rdata_d[num_lanes-1:0] = inj_mask_q;
      addr_inj_pat:  rdata_d                = inj_pat_q;
      addr_perm:     rdata_d[num_lanes-1:0] = perm_i;
      default: begin
        // Unmapped reads stay zero
        if (cnt_hit) begin
          rdata_d[cnt_width-1:0] = cnts[cnt_idx];
        end
      end
    endcase
  end

  // Held until the next read strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (mhpm_re_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign mhpm_rdata_o = rdata_q;
  assign lane_sel_o   = lane_sel_q;
  assign mode_o       = mode_q;
  assign thresh_o     = thresh_q;
  assign inj_mask_o   = inj_mask_q;
  assign inj_pat_o    = inj_pat_q;

endmodule

`default_nettype wire

// File: source/fault_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module fault_monitor #(
  parameter int unsigned cnt_width = ex_ft_pkg::cnt_width
) (
  input  logic                              clk,
  input  logic                              rst_n,
  // ALU strobe qualifies the mismatch vector
  input  logic                              valid_i,
  input  logic [ex_ft_pkg::num_lanes-1:0]   mismatch_i,
  input  logic [cnt_width-1:0]              thresh_i,
  // One-hot clear from the register block
  input  logic [ex_ft_pkg::num_lanes-1:0]   clr_i,
  output logic [cnt_width-1:0]              cnt0_o,
  output logic [cnt_width-1:0]              cnt1_o,
  output logic [cnt_width-1:0]              cnt2_o,
  output logic [cnt_width-1:0]              cnt3_o,
  output logic [ex_ft_pkg::num_lanes-1:0]   perm_o
);

  import ex_ft_pkg::*;

  logic [cnt_width-1:0] cnt_q [num_lanes];
  logic [cnt_width-1:0] cnt_d [num_lanes];
  logic [num_lanes-1:0] perm_d;
  logic [num_lanes-1:0] perm_q;

  ////////////////////
  // Next counts
  ////////////////////

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      cnt_d[i] = cnt_q[i];
      // Clear wins over a count in the same cycle
      if (clr_i[i]) begin
        cnt_d[i] = '0;
      end else if (valid_i && mismatch_i[i] && (cnt_q[i] != '1)) begin
        // Saturates at all ones
        cnt_d[i] = cnt_q[i] + cnt_width'(1);
      end
      // Flag follows the new count
      perm_d[i] = cnt_d[i] >= thresh_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '{default: '0};
      perm_q <= '0;
    end else begin
      cnt_q  <= cnt_d;
      perm_q <= perm_d;
    end
  end

  // Loose readout
  assign cnt0_o = cnt_q[0];
  assign cnt1_o = cnt_q[1];
  assign cnt2_o = cnt_q[2];
  assign cnt3_o = cnt_q[3];
  assign perm_o = perm_q;

endmodule

`default_nettype wire

// File: source/lane_voter.sv
`timescale 1ns/1ps
`default_nettype none

module lane_voter (
  input  logic [ex_ft_pkg::data_width-1:0]     lane0_i,
  input  logic [ex_ft_pkg::data_width-1:0]     lane1_i,
  input  logic [ex_ft_pkg::data_width-1:0]     lane2_i,
  input  logic [ex_ft_pkg::data_width-1:0]     lane3_i,
  // Excluded lane in TMR, the chosen lane in bypass
  input  logic [ex_ft_pkg::lane_idx_width-1:0] lane_sel_i,
  input  ex_ft_pkg::vote_mode_e                mode_i,
  output logic [ex_ft_pkg::data_width-1:0]     result_o,
  output logic                                 err_detected_o,
  output logic                                 err_corrected_o,
  // One-hot, lane outside the majority
  output logic [ex_ft_pkg::num_lanes-1:0]      mismatch_o
);

  import ex_ft_pkg::*;

  logic [data_width-1:0]     lanes [num_lanes];
  logic [lane_idx_width-1:0] idx_x;
  logic [lane_idx_width-1:0] idx_y;
  logic [lane_idx_width-1:0] idx_z;
  logic [data_width-1:0]     x;
  logic [data_width-1:0]     y;
  logic [data_width-1:0]     z;
  logic                      eq_xy;
  logic                      eq_xz;
  logic                      eq_yz;

  assign lanes[0] = lane0_i;
  assign lanes[1] = lane1_i;
  assign lanes[2] = lane2_i;
  assign lanes[3] = lane3_i;

  // Three lanes left after dropping lane_sel, in ascending order
  assign idx_x = (lane_sel_i == 2'd0) ? 2'd1 : 2'd0;
  assign idx_y = (lane_sel_i <= 2'd1) ? 2'd2 : 2'd1;
  assign idx_z = (lane_sel_i == 2'd3) ? 2'd2 : 2'd3;

  assign x = lanes[idx_x];
  assign y = lanes[idx_y];
  assign z = lanes[idx_z];

  // Word compares
  assign eq_xy = x == y;
  assign eq_xz = x == z;
  assign eq_yz = y == z;

  ////////////////////
  // Vote
  ////////////////////

  always_comb begin
    result_o        = x;
    err_detected_o  = 1'b0;
    err_corrected_o = 1'b0;
    mismatch_o      = '0;
    if (mode_i == vote_bypass) begin
      // Single lane, no checking
      result_o = lanes[lane_sel_i];
    end else begin
      err_detected_o = !(eq_xy && eq_xz);
      if (eq_xy || eq_xz) begin
        result_o = x;
        // x agrees with one, the other lost
        if (!eq_xy) begin
          mismatch_o[idx_y] = 1'b1;
        end else if (!eq_xz) begin
          mismatch_o[idx_z] = 1'b1;
        end
      end else if (eq_yz) begin
        result_o          = y;
        mismatch_o[idx_x] = 1'b1;
      end
      // All three differ, x passes uncorrected and nobody is blamed
      err_corrected_o = err_detected_o && (eq_xy || eq_xz || eq_yz);
    end
  end

endmodule

`default_nettype wire

// File: test/tb_ex_stage_ft.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage_ft;

  import ex_ft_pkg::*;

  typedef enum logic [2:0] {k_alu, k_csr, k_load, k_wr, k_rd} kind_e;

  // One table row where a doubles as wdata, csr_rdata or lsu_rdata
  typedef struct packed {
    kind_e                     kind;
    alu_op_e                   op;
    logic [data_width-1:0]     a;
    logic [data_width-1:0]     b;
    logic [reg_addr_width-1:0] addr;
    logic [waddr_width-1:0]    waddr;
    logic                      err;
    logic                      det;
    logic                      cor;
    logic [num_lanes-1:0]      perm;
    logic [data_width-1:0]     rd_exp;
  } entry_t;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      alu_en_i;
  alu_op_e                   alu_operator_i;
  logic [data_width-1:0]     alu_operand_a_i;
  logic [data_width-1:0]     alu_operand_b_i;
  logic [waddr_width-1:0]    regfile_alu_waddr_i;
  logic                      regfile_alu_we_i;
  logic                      csr_access_i;
  logic [data_width-1:0]     csr_rdata_i;
  logic                      lsu_en_i;
  logic                      lsu_err_i;
  logic [waddr_width-1:0]    lsu_waddr_i;
  logic [data_width-1:0]     lsu_rdata_i;
  logic [reg_addr_width-1:0] mhpm_addr_i;
  logic                      mhpm_we_i;
  logic                      mhpm_re_i;
  logic [data_width-1:0]     mhpm_wdata_i;
  logic [data_width-1:0]     mhpm_rdata_o;
  logic                      regfile_alu_we_fw_o;
  logic [waddr_width-1:0]    regfile_alu_waddr_fw_o;
  logic [data_width-1:0]     regfile_alu_wdata_fw_o;
  logic                      regfile_we_wb_o;
  logic [waddr_width-1:0]    regfile_waddr_wb_o;
  logic [data_width-1:0]     regfile_wdata_wb_o;
  logic                      err_detected_o;
  logic                      err_corrected_o;
  logic [num_lanes-1:0]      permanent_faulty_o;
  logic                      ex_valid_o;

  entry_t                    tests [$];
  logic [num_lanes-1:0]      build_perm = '0;
  // Register block state as the testbench expects it
  logic [lane_idx_width-1:0] m_lane_sel = 2'd3;
  vote_mode_e                m_mode = vote_tmr;
  logic [num_lanes-1:0]      m_mask = '0;
  logic [data_width-1:0]     m_pat = '0;
  int                        cycles = 0;
  int                        cycle_limit = 0;

  ex_stage_ft #(.cnt_width(cnt_width)) i_ex_stage_ft (.*);

  always #4 clk = ~clk;

  // Run limit armed once the table is known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("Done: errors found");
      $fatal(1, "Cycle limit reached");
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [data_width-1:0] ref_alu(input alu_op_e op,
      input logic [data_width-1:0] a, input logic [data_width-1:0] b);
    logic [data_width-1:0] r;
    logic [4:0]            sh;
    r  = '0;
    sh = b[4:0];
    case (op)
      op_add:  r = a + b;
      op_sub:  r = a - b;
      op_and:  r = a & b;
      op_or:   r = a | b;
      op_xor:  r = a ^ b;
      op_sll:  r = a << sh;
      op_srl:  r = a >> sh;
      // Logical shift with the vacated bits filled from the sign
      op_sra:  r = (a >> sh) | (~({data_width{1'b1}} >> sh) & {data_width{a[31]}});
      // With different signs the negative one is smaller
      op_slt:  r[0] = (a[31] != b[31]) ? a[31] : (a < b);
      op_sltu: r[0] = a < b;
      op_eq:   r[0] = a == b;
      default: r = '0;
    endcase
    return r;
  endfunction

  // Lane words after injection and the majority rule
  function automatic logic [data_width-1:0] expect_vote(input logic [data_width-1:0] r);
    logic [data_width-1:0] lv [num_lanes];
    logic [data_width-1:0] v [3];
    int                    n;
    n = 0;
    for (int i = 0; i < num_lanes; i++) begin
      lv[i] = m_mask[i] ? (r ^ m_pat) : r;
    end
    if (m_mode == vote_bypass) begin
      return lv[m_lane_sel];
    end
    for (int i = 0; i < num_lanes; i++) begin
      if (i != int'(m_lane_sel)) begin
        v[n] = lv[i];
        n++;
      end
    end
    if ((v[0] == v[1]) || (v[0] == v[2])) begin
      return v[0];
    end
    return (v[1] == v[2]) ? v[1] : v[0];
  endfunction

  task automatic update_model(input logic [reg_addr_width-1:0] addr,
      input logic [data_width-1:0] d);
    case (addr)
      addr_ctrl: begin
        m_lane_sel = d[1:0];
        m_mode     = vote_mode_e'(d[2]);
      end
      addr_inj_mask: m_mask = d[3:0];
      addr_inj_pat:  m_pat  = d;
      default: ;
    endcase
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic report_error(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_word(input string what, input logic [data_width-1:0] got,
      input logic [data_width-1:0] exp);
    if (got !== exp) begin
      report_error($sformatf("%s is %08h, expected %08h", what, got, exp));
    end
  endtask

  task automatic check_addr(input string what, input logic [waddr_width-1:0] got,
      input logic [waddr_width-1:0] exp);
    if (got !== exp) begin
      report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_flags(input logic got_det, input logic got_cor,
      input logic exp_det, input logic exp_cor);
    if ((got_det !== exp_det) || (got_cor !== exp_cor)) begin
      report_error($sformatf("flags det/cor are %b/%b, expected %b/%b",
                             got_det, got_cor, exp_det, exp_cor));
    end
  endtask

  task automatic check_perm(input logic [num_lanes-1:0] got, input logic [num_lanes-1:0] exp);
    if (got !== exp) begin
      report_error($sformatf("permanent flags are %b, expected %b", got, exp));
    end
  endtask

  ////////////////////
  // Table
  ////////////////////

  function automatic entry_t new_entry(input kind_e kind);
    entry_t e;
    e       = '0;
    e.kind  = kind;
    e.op    = op_add;
    e.a     = $urandom;
    e.b     = $urandom;
    e.waddr = waddr_width'($urandom);
    e.perm  = build_perm;
    return e;
  endfunction

  task automatic add_alu(input alu_op_e op, input logic det, input logic cor, input logic same);
    entry_t e;
    e     = new_entry(k_alu);
    e.op  = op;
    e.det = det;
    e.cor = cor;
    // Equal operands for the compare that needs them
    if (same) begin
      e.b = e.a;
    end
    tests.push_back(e);
  endtask

  task automatic add_reg(input kind_e kind, input logic [reg_addr_width-1:0] addr,
      input logic [data_width-1:0] d);
    entry_t e;
    e        = new_entry(kind);
    e.addr   = addr;
    e.a      = d;
    e.rd_exp = d;
    tests.push_back(e);
  endtask

  task automatic add_port(input kind_e kind, input logic err);
    entry_t e;
    e     = new_entry(kind);
    e.err = err;
    tests.push_back(e);
  endtask

  task automatic build_tests();
    // Reset values of the register block
    add_reg(k_rd, addr_ctrl, 32'd3);
    add_reg(k_rd, addr_thresh, 32'd255);
    add_reg(k_rd, addr_inj_mask, 32'd0);
    add_reg(k_rd, addr_cnt_base, 32'd0);
    // Every opcode on clean lanes
    for (int i = 0; i <= 10; i++) begin
      add_alu(alu_op_e'(i), 1'b0, 1'b0, 1'b0);
    end
    add_alu(op_eq, 1'b0, 1'b0, 1'b1);
    // Faulty lane 0 gets outvoted and counted
    add_reg(k_wr, addr_inj_pat, 32'h00f0_0f00);
    add_reg(k_wr, addr_inj_mask, 32'd1);
    add_reg(k_rd, addr_inj_pat, 32'h00f0_0f00);
    add_alu(op_add, 1'b1, 1'b1, 1'b0);
    add_reg(k_rd, addr_cnt_base, 32'd1);
    add_alu(op_xor, 1'b1, 1'b1, 1'b0);
    add_reg(k_rd, addr_cnt_base, 32'd2);
    add_reg(k_wr, addr_thresh, 32'd3);
    // Third count reaches the threshold
    build_perm = 4'b0001;
    add_alu(op_sub, 1'b1, 1'b1, 1'b0);
    add_reg(k_rd, addr_perm, 32'd1);
    build_perm = 4'b0000;
    add_reg(k_wr, addr_cnt_base, 32'd0);
    add_reg(k_rd, addr_cnt_base, 32'd0);
    // Only the excluded lane faulty
    add_reg(k_wr, addr_inj_mask, 32'd8);
    add_alu(op_and, 1'b0, 1'b0, 1'b0);
    add_alu(op_srl, 1'b0, 1'b0, 1'b0);
    // Lanes 0 and 1 agree on a wrong word and lane 2 is blamed
    add_reg(k_wr, addr_inj_mask, 32'd3);
    add_alu(op_add, 1'b1, 1'b1, 1'b0);
    add_reg(k_rd, 4'd10, 32'd1);
    // Bypass on the faulty lane 1 and then on clean lane 2
    add_reg(k_wr, addr_ctrl, 32'd5);
    add_reg(k_wr, addr_inj_mask, 32'd2);
    add_alu(op_or, 1'b0, 1'b0, 1'b0);
    add_alu(op_sra, 1'b0, 1'b0, 1'b0);
    add_reg(k_wr, addr_ctrl, 32'd6);
    add_alu(op_sub, 1'b0, 1'b0, 1'b0);
    // Vote over lanes 1..3 with lane 1 faulty
    add_reg(k_wr, addr_ctrl, 32'd0);
    add_alu(op_xor, 1'b1, 1'b1, 1'b0);
    add_reg(k_rd, 4'd9, 32'd1);
    add_reg(k_rd, addr_ctrl, 32'd0);
    add_reg(k_rd, 4'd5, 32'd0);
    add_reg(k_wr, addr_ctrl, 32'd3);
    add_reg(k_wr, addr_inj_mask, 32'd0);
    add_alu(op_sltu, 1'b0, 1'b0, 1'b0);
    // CSR forwarding and the load port
    add_port(k_csr, 1'b0);
    add_port(k_load, 1'b0);
    add_port(k_load, 1'b1);
    add_port(k_load, 1'b0);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_idle();
    alu_en_i         = 1'b0;
    // Write enable stays high so that only the strobes gate the forward port
    regfile_alu_we_i = 1'b1;
    csr_access_i     = 1'b0;
    lsu_en_i         = 1'b0;
    lsu_err_i        = 1'b0;
    mhpm_we_i        = 1'b0;
    mhpm_re_i        = 1'b0;
  endtask

  task automatic apply_entry(input entry_t e);
    logic [data_width-1:0] exp_res;
    @(negedge clk);
    case (e.kind)
      k_alu: begin
        alu_en_i            = 1'b1;
        alu_operator_i      = e.op;
        alu_operand_a_i     = e.a;
        alu_operand_b_i     = e.b;
        regfile_alu_waddr_i = e.waddr;
        regfile_alu_we_i    = 1'b1;
      end
      k_csr: begin
        csr_access_i        = 1'b1;
        csr_rdata_i         = e.a;
        regfile_alu_waddr_i = e.waddr;
        regfile_alu_we_i    = 1'b1;
      end
      k_load: begin
        lsu_en_i    = 1'b1;
        lsu_err_i   = e.err;
        lsu_waddr_i = e.waddr;
        // Load data only arrives in the write-back cycle
        lsu_rdata_i = ~e.a;
      end
      k_wr: begin
        mhpm_we_i    = 1'b1;
        mhpm_addr_i  = e.addr;
        mhpm_wdata_i = e.a;
      end
      default: begin
        mhpm_re_i   = 1'b1;
        mhpm_addr_i = e.addr;
      end
    endcase
    #1;
    // Combinational outputs in the strobe cycle
    check_bit("load write enable early", regfile_we_wb_o, 1'b0);
    check_flags(err_detected_o, err_corrected_o, e.det, e.cor);
    check_bit("stage valid", ex_valid_o, (e.kind != k_wr) && (e.kind != k_rd));
    if ((e.kind == k_alu) || (e.kind == k_csr)) begin
      exp_res = (e.kind == k_alu) ? expect_vote(ref_alu(e.op, e.a, e.b)) : e.a;
      check_word("forwarded data", regfile_alu_wdata_fw_o, exp_res);
      check_bit("forward enable", regfile_alu_we_fw_o, 1'b1);
      check_addr("forward address", regfile_alu_waddr_fw_o, e.waddr);
    end else begin
      check_bit("forward enable without strobe", regfile_alu_we_fw_o, 1'b0);
    end
    @(negedge clk);
    drive_idle();
    if (e.kind == k_wr) begin
      update_model(e.addr, e.a);
    end
    if (e.kind == k_load) begin
      lsu_rdata_i = e.a;
    end
    #1;
    // Registered outputs one cycle later
    if (e.kind == k_rd) begin
      check_word("register read", mhpm_rdata_o, e.rd_exp);
    end
    if (e.kind == k_load) begin
      check_bit("load write enable", regfile_we_wb_o, !e.err);
      if (!e.err) begin
        check_addr("load address", regfile_waddr_wb_o, e.waddr);
        check_word("load data", regfile_wdata_wb_o, e.a);
      end
    end
    check_perm(permanent_faulty_o, e.perm);
  endtask

  initial begin
    void'($urandom(78));
    rst_n               = 1'b0;
    drive_idle();
    alu_operator_i      = op_add;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    regfile_alu_waddr_i = '0;
    csr_rdata_i         = '0;
    lsu_waddr_i         = '0;
    lsu_rdata_i         = '0;
    mhpm_addr_i         = '0;
    mhpm_wdata_i        = '0;
    build_tests();
    cycle_limit = 2 * tests.size() * 4;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_perm(permanent_faulty_o, 4'b0000);
    check_bit("load write enable after reset", regfile_we_wb_o, 1'b0);
    foreach (tests[i]) begin
      apply_entry(tests[i]);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire
